// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mem_stage
FILELIST  ?= mem_stage_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= Test completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard include/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/data_sram_model.sv ====
`timescale 1ns/1ps

module data_sram_model (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req_i,
    input  logic                      wr_i,
    input  mem_stage_pkg::xfer_size_e size_i,
    input  mem_stage_pkg::word_t      addr_i,
    input  mem_stage_pkg::word_t      wdata_i,
    output logic                      addr_ok_o,
    output logic                      data_ok_o,
    output mem_stage_pkg::word_t      rdata_o
);
    import mem_stage_pkg::*;

    word_t      mem [0:63];
    integer     seed;
    integer     addr_wait;
    integer     data_wait;
    logic       pending;
    logic       cur_wr;
    xfer_size_e cur_size;
    word_t      cur_addr;
    word_t      cur_wdata;
    logic [3:0] lanes;

    initial begin
        seed = 32'h8bfd_a11a;
    end

    // Byte lanes touched by the accepted store
    always_comb begin
        case (cur_size)
            SIZE_BYTE: lanes = 4'b0001 << cur_addr[1:0];
            SIZE_HALF: lanes = cur_addr[1] ? 4'b1100 : 4'b0011;
            default: lanes = 4'b1111;
        endcase
    end

    assign addr_ok_o = req_i && !pending && (addr_wait == 0);
    assign data_ok_o = pending && (data_wait == 0);
    assign rdata_o   = mem[cur_addr[7:2]];

    always @(posedge clk) begin
        if (rst) begin
            pending   <= 1'b0;
            data_wait <= 0;
            addr_wait <= $unsigned($random(seed)) % 3;
            for (int i = 0; i < 64; i++) begin
                mem[i] <= 32'h9e37_79b9 * (i + 1);
            end
        end else if (pending) begin
            if (data_wait == 0) begin
                pending   <= 1'b0;
                addr_wait <= $unsigned($random(seed)) % 3;
                if (cur_wr) begin
                    for (int k = 0; k < 4; k++) begin
                        if (lanes[k]) begin
                            mem[cur_addr[7:2]][8*k +: 8] <= cur_wdata[8*k +: 8];
                        end
                    end
                end
            end else begin
                data_wait <= data_wait - 1;
            end
        end else if (req_i) begin
            if (addr_wait == 0) begin
                // Accepted, data strobe follows 1 to 3 cycles later
                pending   <= 1'b1;
                data_wait <= $unsigned($random(seed)) % 3;
                cur_wr    <= wr_i;
                cur_size  <= size_i;
                cur_addr  <= addr_i;
                cur_wdata <= wdata_i;
            end else begin
                addr_wait <= addr_wait - 1;
            end
        end
    end

endmodule

// ==== bench/tb_mem_stage.sv ====
`timescale 1ns/1ps
`include "mem_stage_cfg.svh"

module tb_mem_stage;
    import mem_stage_pkg::*;

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 4;
    localparam int CYCLES_PER_TEST = 40;
    localparam exc_code_t EXC_NONE = '0;
    localparam exc_code_t EXC_ADEL = exc_code_t'(`MEM_EXC_ADEL);
    localparam exc_code_t EXC_ADES = exc_code_t'(`MEM_EXC_ADES);

    typedef struct packed {
        mem_op_e   op;
        word_t     addr;
        word_t     reg2;
        reg_addr_t wd;
        logic      wreg;
        word_t     wdata;
        exc_code_t exp_exc;
        logic      exp_req;
    } entry_t;

    logic       clk;
    logic       rst;
    mem_op_e    op_i;
    word_t      addr_i;
    word_t      reg2_i;
    reg_addr_t  wd_i;
    logic       wreg_i;
    word_t      wdata_i;
    word_t      data_rdata;
    logic       data_addr_ok;
    logic       data_data_ok;
    reg_addr_t  wd_o;
    logic       wreg_o;
    word_t      wdata_o;
    exc_code_t  except_code_o;
    logic       stall_o;
    logic       data_req_o;
    logic       data_wr_o;
    xfer_size_e data_size_o;
    word_t      data_addr_o;
    word_t      data_wdata_o;

    entry_t     entries[$];
    logic [7:0] shadow [0:255];
    logic       table_ready;
    int         checks;
    int         errors;
    int         entry_errors;

    mem_stage_top dut0 (
        .clk            (clk),
        .rst            (rst),
        .op_i           (op_i),
        .addr_i         (addr_i),
        .reg2_i         (reg2_i),
        .wd_i           (wd_i),
        .wreg_i         (wreg_i),
        .wdata_i        (wdata_i),
        .data_rdata_i   (data_rdata),
        .data_addr_ok_i (data_addr_ok),
        .data_data_ok_i (data_data_ok),
        .wd_o           (wd_o),
        .wreg_o         (wreg_o),
        .wdata_o        (wdata_o),
        .except_code_o  (except_code_o),
        .stall_o        (stall_o),
        .data_req_o     (data_req_o),
        .data_wr_o      (data_wr_o),
        .data_size_o    (data_size_o),
        .data_addr_o    (data_addr_o),
        .data_wdata_o   (data_wdata_o)
    );

    data_sram_model sram0 (
        .clk       (clk),
        .rst       (rst),
        .req_i     (data_req_o),
        .wr_i      (data_wr_o),
        .size_i    (data_size_o),
        .addr_i    (data_addr_o),
        .wdata_i   (data_wdata_o),
        .addr_ok_o (data_addr_ok),
        .data_ok_o (data_data_ok),
        .rdata_o   (data_rdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic compare(string name, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            entry_errors++;
            $display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic add_entry(mem_op_e op, word_t addr, word_t reg2, reg_addr_t wd,
                             logic wreg, word_t wdata, exc_code_t exc, logic req);
        entry_t e;
        e = '{op, addr, reg2, wd, wreg, wdata, exc, req};
        entries.push_back(e);
    endtask

    function automatic logic is_store(mem_op_e op);
        return op == OP_SB || op == OP_SH || op == OP_SW;
    endfunction

    function automatic xfer_size_e op_size(mem_op_e op);
        case (op)
            OP_LB, OP_LBU, OP_SB: return SIZE_BYTE;
            OP_LH, OP_LHU, OP_SH: return SIZE_HALF;
            default: return SIZE_WORD;
        endcase
    endfunction

    // Each bus byte lane carries the matching byte of the stored value
    function automatic word_t replicated_store_word(mem_op_e op, word_t reg2);
        int    n;
        word_t w;
        n = (op == OP_SB) ? 1 : (op == OP_SH) ? 2 : 4;
        for (int k = 0; k < 4; k++) begin
            w[8*k +: 8] = reg2[8*(k % n) +: 8];
        end
        return w;
    endfunction

    // Little endian view of the shadow bytes
    function automatic word_t expected_load(mem_op_e op, word_t addr);
        logic [7:0]  a;
        logic [7:0]  b;
        logic [15:0] h;
        word_t       w;
        a = addr[7:0];
        b = shadow[a];
        h = {shadow[a + 8'd1], shadow[a]};
        w = {shadow[a + 8'd3], shadow[a + 8'd2], shadow[a + 8'd1], shadow[a]};
        case (op)
            OP_LB: return {{24{b[7]}}, b};
            OP_LBU: return {24'b0, b};
            OP_LH: return {{16{h[15]}}, h};
            OP_LHU: return {16'b0, h};
            default: return w;
        endcase
    endfunction

    task automatic update_shadow(mem_op_e op, word_t addr, word_t reg2);
        int n;
        n = (op == OP_SB) ? 1 : (op == OP_SH) ? 2 : 4;
        for (int k = 0; k < n; k++) begin
            shadow[addr[7:0] + 8'(k)] = reg2[8*k +: 8];
        end
    endtask

    task automatic build_table();
        add_entry(OP_NONE, 32'h03, 32'h0000_0000, 5'd3, 1'b1, 32'h1234_5678, EXC_NONE, 1'b0);
        add_entry(OP_SW, 32'h10, 32'h1122_3344, 5'd0, 1'b0, 32'h0000_0000, EXC_NONE, 1'b1);
        add_entry(OP_SH, 32'h12, 32'haaaa_beef, 5'd0, 1'b0, 32'h0000_0000, EXC_NONE, 1'b1);
        add_entry(OP_SB, 32'h11, 32'h0000_00c5, 5'd0, 1'b0, 32'h0000_0000, EXC_NONE, 1'b1);
        add_entry(OP_LW, 32'h10, 32'h0000_0000, 5'd4, 1'b1, 32'h0000_0000, EXC_NONE, 1'b1);
        add_entry(OP_SW, 32'h20, 32'h80f1_7f02, 5'd0, 1'b0, 32'h0000_0000, EXC_NONE, 1'b1);
        for (int i = 0; i < 4; i++) begin
            add_entry(OP_LB, 32'h20 + i, 32'h0, 5'd7, 1'b1, 32'h0, EXC_NONE, 1'b1);
            add_entry(OP_LBU, 32'h20 + i, 32'h0, 5'd8, 1'b1, 32'h0, EXC_NONE, 1'b1);
        end
        add_entry(OP_LH, 32'h20, 32'h0000_0000, 5'd5, 1'b1, 32'h0000_0000, EXC_NONE, 1'b1);
        add_entry(OP_LH, 32'h22, 32'h0000_0000, 5'd5, 1'b1, 32'h0000_0000, EXC_NONE, 1'b1);
        add_entry(OP_LHU, 32'h20, 32'h0000_0000, 5'd6, 1'b1, 32'h0000_0000, EXC_NONE, 1'b1);
        add_entry(OP_LHU, 32'h22, 32'h0000_0000, 5'd6, 1'b1, 32'h0000_0000, EXC_NONE, 1'b1);
        // Misaligned accesses never reach the bus
        add_entry(OP_LH, 32'h21, 32'h0000_0000, 5'd2, 1'b1, 32'h0000_0000, EXC_ADEL, 1'b0);
        add_entry(OP_LW, 32'h22, 32'h0000_0000, 5'd2, 1'b1, 32'h0000_0000, EXC_ADEL, 1'b0);
        add_entry(OP_SH, 32'h23, 32'hdead_dead, 5'd1, 1'b1, 32'h0000_0000, EXC_ADES, 1'b0);
        add_entry(OP_SW, 32'h11, 32'hdead_dead, 5'd1, 1'b1, 32'h0000_0000, EXC_ADES, 1'b0);
        add_entry(OP_LW, 32'h10, 32'h0000_0000, 5'd9, 1'b1, 32'h0000_0000, EXC_NONE, 1'b1);
        add_entry(OP_LW, 32'h20, 32'h0000_0000, 5'd9, 1'b1, 32'h0000_0000, EXC_NONE, 1'b1);
        add_entry(OP_NONE, 32'h00, 32'h0000_0000, 5'd12, 1'b0, 32'hffff_0000, EXC_NONE, 1'b0);
    endtask

    task automatic run_entry(int idx, entry_t e);
        mem_op_e op;
        logic    req_seen;
        op = e.op;
        req_seen = 1'b0;
        entry_errors = 0;
        @(posedge clk);
        op_i    <= e.op;
        addr_i  <= e.addr;
        reg2_i  <= e.reg2;
        wd_i    <= e.wd;
        wreg_i  <= e.wreg;
        wdata_i <= e.wdata;
        @(negedge clk);
        compare("except_code_o", 32'(except_code_o), 32'(e.exp_exc));
        while (stall_o) begin
            compare("wreg_o", 32'(wreg_o), 32'd0);
            if (data_req_o) begin
                req_seen = 1'b1;
                compare("data_addr_o", data_addr_o, e.addr);
                compare("data_wr_o", 32'(data_wr_o), 32'(is_store(op)));
                compare("data_size_o", 32'(data_size_o), 32'(op_size(op)));
                if (is_store(op)) begin
                    compare("data_wdata_o", data_wdata_o, replicated_store_word(op, e.reg2));
                end
            end
            @(negedge clk);
        end
        checks++;
        if (req_seen != e.exp_req) begin
            errors++;
            entry_errors++;
            $display("Entry %0d: bus request presence was wrong at %0t ns", idx, $time);
        end
        if (e.exp_req) begin
            // Stall may only drop on the data strobe
            compare("data_data_ok_i", 32'(data_data_ok), 32'd1);
        end
        if (e.exp_req && !is_store(op)) begin
            compare("wreg_o", 32'(wreg_o), 32'd1);
            compare("wd_o", 32'(wd_o), 32'(e.wd));
            compare("wdata_o", wdata_o, expected_load(op, e.addr));
        end else if (e.exp_req || e.exp_exc != EXC_NONE) begin
            compare("wreg_o", 32'(wreg_o), 32'd0);
        end else begin
            compare("wreg_o", 32'(wreg_o), 32'(e.wreg));
            compare("wd_o", 32'(wd_o), 32'(e.wd));
            compare("wdata_o", wdata_o, e.wdata);
        end
        if (e.exp_req && is_store(op)) begin
            update_shadow(op, e.addr, e.reg2);
        end
        if (entry_errors == 0) begin
            $display("Entry %0d %s addr %h: ok", idx, op.name(), e.addr);
        end else begin
            $display("Entry %0d %s addr %h: %0d mismatches", idx, op.name(), e.addr,
                     entry_errors);
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        op_i         = OP_NONE;
        addr_i       = '0;
        reg2_i       = '0;
        wd_i         = '0;
        wreg_i       = 1'b0;
        wdata_i      = '0;
        checks       = 0;
        errors       = 0;
        entry_errors = 0;
        table_ready  = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compare("data_req_o", 32'(data_req_o), 32'd0);
        compare("stall_o", 32'(stall_o), 32'd0);
        compare("wreg_o", 32'(wreg_o), 32'd0);
        for (int i = 0; i < entries.size(); i++) begin
            run_entry(i, entries[i]);
        end
        @(posedge clk);
        op_i <= OP_NONE;
        $display("Entries: %0d, checks: %0d, errors: %0d", entries.size(), checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (table_ready);
        repeat (CYCLES_PER_TEST * entries.size() + RESET_CYCLES) @(posedge clk);
        $display("Timeout: the operation table did not finish in time");
        $display("Test failed");
        $finish;
    end

endmodule

// ==== include/mem_stage_cfg.svh ====
`ifndef MEM_STAGE_CFG_SVH
`define MEM_STAGE_CFG_SVH

// Datapath widths
`define MEM_DATA_W      32
`define MEM_REG_ADDR_W  5
`define MEM_OP_W        8

// Address error codes, load and store
`define MEM_EXC_ADEL    4
`define MEM_EXC_ADES    5
`define MEM_EXC_W       5

`endif

// ==== mem_stage_top.f ====
+incdir+include
src/mem_stage_pkg.sv
src/mem_req_if.sv
src/load_done_if.sv
src/mem_access_decode.sv
src/data_bus_ctrl.sv
src/load_writeback.sv
src/mem_stage_top.sv
bench/data_sram_model.sv
bench/tb_mem_stage.sv

// ==== src/data_bus_ctrl.sv ====
`timescale 1ns/1ps

module data_bus_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      data_addr_ok_i,
    input  logic                      data_data_ok_i,
    input  mem_stage_pkg::word_t      data_rdata_i,
    mem_req_if.ctrl                   req,
    output logic                      data_req_o,
    output logic                      data_wr_o,
    output mem_stage_pkg::xfer_size_e data_size_o,
    output mem_stage_pkg::word_t      data_addr_o,
    output mem_stage_pkg::word_t      data_wdata_o,
    output logic                      stall_o,
    output logic                      busy_o,
    load_done_if.ctrl                 done
);
    import mem_stage_pkg::*;

    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        ADDR_WAIT = 2'd1,
        DATA_WAIT = 2'd2
    } bus_state_e;

    bus_state_e state;
    logic       idle;

    // Copy of the request once it leaves IDLE
    logic       saved_wr;
    xfer_size_e saved_size;
    word_t      saved_addr;
    word_t      saved_wdata;
    load_kind_e saved_kind;
    reg_addr_t  saved_wd;

    assign idle = (state == IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (req.valid) begin
                        state <= data_addr_ok_i ? DATA_WAIT : ADDR_WAIT;
                    end
                end
                ADDR_WAIT: begin
                    if (data_addr_ok_i) begin
                        state <= DATA_WAIT;
                    end
                end
                DATA_WAIT: begin
                    if (data_data_ok_i) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (idle && req.valid) begin
            saved_wr    <= req.wr;
            saved_size  <= req.size;
            saved_addr  <= req.addr;
            saved_wdata <= req.wdata;
            saved_kind  <= req.kind;
            saved_wd    <= req.wd;
        end
    end

    // Live request in IDLE, replayed copy while waiting for accept
    assign data_req_o   = idle ? req.valid : (state == ADDR_WAIT);
    assign data_wr_o    = data_req_o && (idle ? req.wr : saved_wr);
    assign data_size_o  = idle ? req.size : saved_size;
    assign data_addr_o  = idle ? req.addr : saved_addr;
    assign data_wdata_o = idle ? req.wdata : saved_wdata;

    assign stall_o = data_req_o || (!idle && !data_data_ok_i);
    assign busy_o  = !idle;

    assign done.done    = (state == DATA_WAIT) && data_data_ok_i;
    assign done.is_load = !saved_wr;
    assign done.kind    = saved_kind;
    assign done.addr_lo = saved_addr[1:0];
    assign done.wd      = saved_wd;
    assign done.rdata   = data_rdata_i;

endmodule

// ==== src/load_done_if.sv ====
`timescale 1ns/1ps

// Completed transfer handed to writeback
interface load_done_if;

    logic                      done;
    logic                      is_load;
    mem_stage_pkg::load_kind_e kind;
    logic [1:0]                addr_lo;
    mem_stage_pkg::reg_addr_t  wd;
    mem_stage_pkg::word_t      rdata;

    modport ctrl (
        output done,
        output is_load,
        output kind,
        output addr_lo,
        output wd,
        output rdata
    );

    modport wb (
        input done,
        input is_load,
        input kind,
        input addr_lo,
        input wd,
        input rdata
    );

endinterface

// ==== src/load_writeback.sv ====
`timescale 1ns/1ps

module load_writeback (
    input  mem_stage_pkg::reg_addr_t wd_i,
    input  logic                     wreg_i,
    input  mem_stage_pkg::word_t     wdata_i,
    input  mem_stage_pkg::exc_code_t except_code_i,
    input  logic                     req_valid_i,
    input  logic                     busy_i,
    load_done_if.wb                  done,
    output mem_stage_pkg::reg_addr_t wd_o,
    output logic                     wreg_o,
    output mem_stage_pkg::word_t     wdata_o
);
    import mem_stage_pkg::*;

    logic [7:0]  lane_byte;
    logic [15:0] lane_half;
    word_t       load_data;

    // Pick the addressed lane of the returned word
    always_comb begin
        case (done.addr_lo)
            2'd0: lane_byte = done.rdata[7:0];
            2'd1: lane_byte = done.rdata[15:8];
            2'd2: lane_byte = done.rdata[23:16];
            default: lane_byte = done.rdata[31:24];
        endcase
        lane_half = done.addr_lo[1] ? done.rdata[31:16] : done.rdata[15:0];
    end

    always_comb begin
        case (done.kind)
            LK_BYTE_S: load_data = {{24{lane_byte[7]}}, lane_byte};
            LK_BYTE_U: load_data = {24'b0, lane_byte};
            LK_HALF_S: load_data = {{16{lane_half[15]}}, lane_half};
            LK_HALF_U: load_data = {16'b0, lane_half};
            default: load_data = done.rdata;
        endcase
    end

    always_comb begin
        if (done.done) begin
            // Completion cycle, only loads write a register
            wd_o    = done.wd;
            wdata_o = load_data;
            wreg_o  = done.is_load;
        end else begin
            wd_o    = wd_i;
            wdata_o = wdata_i;
            wreg_o  = wreg_i && !req_valid_i && !busy_i && (except_code_i == '0);
        end
    end

endmodule

// ==== src/mem_access_decode.sv ====
`timescale 1ns/1ps
`include "mem_stage_cfg.svh"

module mem_access_decode (
    input  mem_stage_pkg::mem_op_e   op_i,
    input  mem_stage_pkg::word_t     addr_i,
    input  mem_stage_pkg::word_t     reg2_i,
    input  mem_stage_pkg::reg_addr_t wd_i,
    output mem_stage_pkg::exc_code_t except_code_o,
    mem_req_if.decode                req
);
    import mem_stage_pkg::*;

    logic       is_mem;
    logic       is_store;
    logic       misaligned;
    xfer_size_e size;
    load_kind_e kind;
    word_t      store_word;

    always_comb begin
        is_mem     = 1'b1;
        is_store   = 1'b0;
        size       = SIZE_WORD;
        kind       = LK_WORD;
        store_word = '0;
        case (op_i)
            OP_LB: begin
                size = SIZE_BYTE;
                kind = LK_BYTE_S;
            end
            OP_LBU: begin
                size = SIZE_BYTE;
                kind = LK_BYTE_U;
            end
            OP_LH: begin
                size = SIZE_HALF;
                kind = LK_HALF_S;
            end
            OP_LHU: begin
                size = SIZE_HALF;
                kind = LK_HALF_U;
            end
            OP_LW: begin
                size = SIZE_WORD;
                kind = LK_WORD;
            end
            // Store data is replicated so every lane carries it
            OP_SB: begin
                is_store   = 1'b1;
                size       = SIZE_BYTE;
                store_word = {4{reg2_i[7:0]}};
            end
            OP_SH: begin
                is_store   = 1'b1;
                size       = SIZE_HALF;
                store_word = {2{reg2_i[15:0]}};
            end
            OP_SW: begin
                is_store   = 1'b1;
                size       = SIZE_WORD;
                store_word = reg2_i;
            end
            default: begin
                is_mem = 1'b0;
            end
        endcase
    end

    assign misaligned = is_mem &&
                        ((size == SIZE_HALF && addr_i[0]) ||
                         (size == SIZE_WORD && addr_i[1:0] != 2'b00));

    assign except_code_o = !misaligned ? '0 :
                           is_store ? exc_code_t'(`MEM_EXC_ADES) : exc_code_t'(`MEM_EXC_ADEL);

    assign req.valid = is_mem && !misaligned;
    assign req.wr    = is_store;
    assign req.size  = size;
    assign req.addr  = addr_i;
    assign req.wdata = store_word;
    assign req.kind  = kind;
    assign req.wd    = wd_i;

endmodule

// ==== src/mem_req_if.sv ====
`timescale 1ns/1ps

// One decoded data bus request
interface mem_req_if;

    logic                      valid;
    logic                      wr;
    mem_stage_pkg::xfer_size_e size;
    mem_stage_pkg::word_t      addr;
    mem_stage_pkg::word_t      wdata;
    mem_stage_pkg::load_kind_e kind;
    mem_stage_pkg::reg_addr_t  wd;

    modport decode (
        output valid,
        output wr,
        output size,
        output addr,
        output wdata,
        output kind,
        output wd
    );

    modport ctrl (
        input valid,
        input wr,
        input size,
        input addr,
        input wdata,
        input kind,
        input wd
    );

endinterface

// ==== src/mem_stage_pkg.sv ====
`include "mem_stage_cfg.svh"

package mem_stage_pkg;

    typedef logic [`MEM_DATA_W-1:0] word_t;
    typedef logic [`MEM_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`MEM_EXC_W-1:0] exc_code_t;

    // Operation codes from execute
    typedef enum logic [`MEM_OP_W-1:0] {
        OP_NONE = 8'h00,
        OP_LB   = 8'he0,
        OP_LH   = 8'he1,
        OP_LW   = 8'he3,
        OP_LBU  = 8'he4,
        OP_LHU  = 8'he5,
        OP_SB   = 8'he8,
        OP_SH   = 8'he9,
        OP_SW   = 8'heb
    } mem_op_e;

    // Bus transfer size
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } xfer_size_e;

    // How returned data is extracted and extended
    typedef enum logic [2:0] {
        LK_BYTE_S = 3'd0,
        LK_BYTE_U = 3'd1,
        LK_HALF_S = 3'd2,
        LK_HALF_U = 3'd3,
        LK_WORD   = 3'd4
    } load_kind_e;

endpackage

// ==== src/mem_stage_top.sv ====
`timescale 1ns/1ps

module mem_stage_top (
    input  logic                      clk,
    input  logic                      rst,
    input  mem_stage_pkg::mem_op_e    op_i,
    input  mem_stage_pkg::word_t      addr_i,
    input  mem_stage_pkg::word_t      reg2_i,
    input  mem_stage_pkg::reg_addr_t  wd_i,
    input  logic                      wreg_i,
    input  mem_stage_pkg::word_t      wdata_i,
    input  mem_stage_pkg::word_t      data_rdata_i,
    input  logic                      data_addr_ok_i,
    input  logic                      data_data_ok_i,
    output mem_stage_pkg::reg_addr_t  wd_o,
    output logic                      wreg_o,
    output mem_stage_pkg::word_t      wdata_o,
    output mem_stage_pkg::exc_code_t  except_code_o,
    output logic                      stall_o,
    output logic                      data_req_o,
    output logic                      data_wr_o,
    output mem_stage_pkg::xfer_size_e data_size_o,
    output mem_stage_pkg::word_t      data_addr_o,
    output mem_stage_pkg::word_t      data_wdata_o
);
    import mem_stage_pkg::*;

    exc_code_t except_code;
    logic      busy;

    mem_req_if   req_bus ();
    load_done_if done_bus ();

    mem_access_decode u_decode (
        .op_i          (op_i),
        .addr_i        (addr_i),
        .reg2_i        (reg2_i),
        .wd_i          (wd_i),
        .except_code_o (except_code),
        .req           (req_bus.decode)
    );

    data_bus_ctrl u_bus_ctrl (
        .clk            (clk),
        .rst            (rst),
        .data_addr_ok_i (data_addr_ok_i),
        .data_data_ok_i (data_data_ok_i),
        .data_rdata_i   (data_rdata_i),
        .req            (req_bus.ctrl),
        .data_req_o     (data_req_o),
        .data_wr_o      (data_wr_o),
        .data_size_o    (data_size_o),
        .data_addr_o    (data_addr_o),
        .data_wdata_o   (data_wdata_o),
        .stall_o        (stall_o),
        .busy_o         (busy),
        .done           (done_bus.ctrl)
    );

    load_writeback u_writeback (
        .wd_i          (wd_i),
        .wreg_i        (wreg_i),
        .wdata_i       (wdata_i),
        .except_code_i (except_code),
        .req_valid_i   (req_bus.valid),
        .busy_i        (busy),
        .done          (done_bus.wb),
        .wd_o          (wd_o),
        .wreg_o        (wreg_o),
        .wdata_o       (wdata_o)
    );

    assign except_code_o = except_code;

endmodule
